//--- verilog/sdramPkg.sv
// Fixed 13-bit address, 8-bit data and four banks; the column field holds at most 10 bits
`default_nettype none

package sdramPkg;

    // Fixed bus widths of the device
    localparam int addrBits = 13;
    localparam int dataBits = 8;
    localparam int bankBits = 2;
    localparam int numBanks = 4;

    // Decoded command, one per sampled edge
    typedef enum logic [2:0] {
        nop,
        active,
        read,
        write,
        precharge,
        autoRefresh,
        burstTerm,
        loadMode
    } sdramCmdE;

    // Mode register, in address bit order A9..A0
    typedef struct packed {
        logic [2:0] reserved;
        logic [2:0] casLatency;
        // 0 sequential, 1 interleaved
        logic       burstType;
        logic [2:0] burstLen;
    } sdramModeT;

    // Address word as seen by loadMode
    typedef struct packed {
        logic [2:0] upper;
        sdramModeT  mode;
    } sdramModeWordT;

    // Address word as seen by read, write and precharge
    typedef struct packed {
        logic [1:0] spare;
        // Auto precharge, or all banks on precharge
        logic       autoPre;
        logic [9:0] col;
    } sdramColWordT;

    typedef union packed {
        sdramModeWordT modeWord;
        sdramColWordT  colWord;
    } sdramAddrU;

    // Command bus as sampled on one edge
    typedef struct packed {
        sdramCmdE            cmd;
        logic [bankBits-1:0] bank;
        sdramAddrU           addr;
    } sdramCmdT;

    // One slot of the CAS latency pipeline
    typedef struct packed {
        sdramCmdE            kind;
        logic [bankBits-1:0] bank;
        logic                allBanks;
    } casEntryT;

endpackage

`default_nettype wire

//--- verilog/sdramCmdDecode.sv
// Only burst lengths 1 to 8 and CAS latency 2 or 3 are supported; CKE is taken as always high
`default_nettype none

module sdramCmdDecode (
    input  logic                              Clk,
    input  logic                              rstN,
    input  logic                              csN,
    input  logic                              rasN,
    input  logic                              casN,
    input  logic                              weN,
    input  logic [sdramPkg::bankBits-1:0]     ba,
    input  sdramPkg::sdramAddrU               addr,
    output sdramPkg::sdramCmdT                cmdNow,
    output sdramPkg::sdramModeT               mode
);

    // Strobe decode, deselect reads as nop
    always_comb begin
        cmdNow.bank = ba;
        cmdNow.addr = addr;
        if (csN) begin
            cmdNow.cmd = sdramPkg::nop;
        end else begin
            case ({rasN, casN, weN})
                3'b000:  cmdNow.cmd = sdramPkg::loadMode;
                3'b001:  cmdNow.cmd = sdramPkg::autoRefresh;
                3'b010:  cmdNow.cmd = sdramPkg::precharge;
                3'b011:  cmdNow.cmd = sdramPkg::active;
                3'b100:  cmdNow.cmd = sdramPkg::write;
                3'b101:  cmdNow.cmd = sdramPkg::read;
                3'b110:  cmdNow.cmd = sdramPkg::burstTerm;
                default: cmdNow.cmd = sdramPkg::nop;
            endcase
        end
    end

    // Mode register, BL 1 sequential CL 2 out of reset
    always_ff @(posedge Clk) begin
        if (!rstN) begin
            mode <= '{reserved: 3'd0, casLatency: 3'd2, burstType: 1'b0, burstLen: 3'd0};
        end else if (cmdNow.cmd == sdramPkg::loadMode) begin
            mode <= addr.modeWord.mode;
        end
    end

    modeSupported: assert property (@(posedge Clk) disable iff (!rstN)
        cmdNow.cmd == sdramPkg::loadMode |->
            addr.modeWord.mode.burstLen <= 3'd3 &&
            (addr.modeWord.mode.casLatency == 3'd2 || addr.modeWord.mode.casLatency == 3'd3))
        else $error("loadMode with unsupported burst length or CAS latency");

endmodule

`default_nettype wire

//--- verilog/sdramBankState.sv
// rowBits must not exceed the 13-bit address; no tRCD or tRP spacing is checked
`default_nettype none

module sdramBankState #(
    parameter int rowBits = 6
) (
    input  logic                                       Clk,
    input  logic                                       rstN,
    input  sdramPkg::sdramCmdT                         cmdNow,
    output logic [sdramPkg::numBanks-1:0][rowBits-1:0] openRows,
    output logic [sdramPkg::numBanks-1:0]              bankOpen,
    output logic                                       protoErr
);

    logic [sdramPkg::addrBits-1:0] addrWord;
    logic                          accessIdle;
    logic                          needAllIdle;

    // Row address comes from the raw address word
    assign addrWord = cmdNow.addr;

    assign accessIdle = (cmdNow.cmd == sdramPkg::read || cmdNow.cmd == sdramPkg::write) &&
                        !bankOpen[cmdNow.bank];
    assign needAllIdle = (cmdNow.cmd == sdramPkg::autoRefresh ||
                          cmdNow.cmd == sdramPkg::loadMode) && (|bankOpen);

    // Open flags per bank
    always_ff @(posedge Clk) begin
        if (!rstN) begin
            bankOpen <= '0;
        end else if (cmdNow.cmd == sdramPkg::active) begin
            bankOpen[cmdNow.bank] <= 1'b1;
        end else if (cmdNow.cmd == sdramPkg::precharge) begin
            if (cmdNow.addr.colWord.autoPre) begin
                bankOpen <= '0;
            end else begin
                bankOpen[cmdNow.bank] <= 1'b0;
            end
        end
    end

    // Row latch on activate
    always_ff @(posedge Clk) begin
        if (cmdNow.cmd == sdramPkg::active) begin
            openRows[cmdNow.bank] <= addrWord[rowBits-1:0];
        end
    end

    // One cycle pulse after the offending edge
    always_ff @(posedge Clk) begin
        if (!rstN) begin
            protoErr <= 1'b0;
        end else begin
            protoErr <= accessIdle || needAllIdle;
        end
    end

    activateIdleOnly: assert property (@(posedge Clk) disable iff (!rstN)
        cmdNow.cmd == sdramPkg::active |-> !bankOpen[cmdNow.bank])
        else $error("active to bank %0d which is still open", cmdNow.bank);

endmodule

`default_nettype wire

//--- verilog/sdramBurstCtrl.sv
// Needs 3 <= colBits <= 10; the running burst follows the mode register as it is now
`default_nettype none

module sdramBurstCtrl #(
    parameter int rowBits = 6,
    parameter int colBits = 8
) (
    input  logic                                       Clk,
    input  logic                                       rstN,
    input  sdramPkg::sdramCmdT                         cmdNow,
    input  sdramPkg::sdramModeT                        mode,
    input  logic [sdramPkg::numBanks-1:0][rowBits-1:0] openRows,
    input  logic [sdramPkg::numBanks-1:0]              bankOpen,
    output logic                                       arrWrEn,
    output logic                                       arrRdEn,
    output logic [sdramPkg::bankBits-1:0]              arrBank,
    output logic [rowBits-1:0]                         arrRow,
    output logic [colBits-1:0]                         arrCol,
    output logic                                       dqOe
);

    localparam sdramPkg::casEntryT idleEntry = '{kind: sdramPkg::nop, bank: '0, allBanks: 1'b0};

    // Two registered slots, the head is acted on in the cycle before edge CL-1
    sdramPkg::casEntryT            casPipe [2];
    logic [colBits-1:0]            pipeCol [2];

    logic [sdramPkg::bankBits-1:0] actBank;
    logic [rowBits-1:0]            actRow;
    logic [colBits-1:0]            startCol;
    logic [2:0]                    beatCnt;
    logic                          rdActive;
    logic                          wrActive;

    logic [2:0]                    wrapMask;
    logic [colBits-1:0]            cmdCol;
    logic                          cmdOpen;
    logic                          pipeIn;
    logic                          wrStart;
    logic                          rdStart;
    logic                          wrStop;
    logic                          rdStop;
    logic                          starting;
    logic                          lastBeat;
    logic [sdramPkg::bankBits-1:0] selBank;
    logic [colBits-1:0]            newCol;

    // Column of a beat, wrapped inside the burst block
    function automatic logic [colBits-1:0] burstCol(input logic [colBits-1:0] base,
                                                    input logic [2:0] count,
                                                    input logic [2:0] mask,
                                                    input logic interleave);
        logic [2:0] low;
        logic [colBits-1:0] result;
        low = interleave ? (base[2:0] ^ count) : (base[2:0] + count);
        result = base;
        result[2:0] = (base[2:0] & ~mask) | (low & mask);
        return result;
    endfunction

    assign wrapMask = 3'b111 >> (2'd3 - mode.burstLen[1:0]);
    assign cmdCol   = cmdNow.addr.colWord.col[colBits-1:0];
    assign cmdOpen  = bankOpen[cmdNow.bank];
    assign pipeIn   = (cmdNow.cmd == sdramPkg::read && cmdOpen) ||
                      cmdNow.cmd == sdramPkg::burstTerm || cmdNow.cmd == sdramPkg::precharge;
    assign lastBeat = (beatCnt == wrapMask);

    // Start and stop conditions
    assign wrStart = (cmdNow.cmd == sdramPkg::write) && cmdOpen;
    assign rdStart = (casPipe[0].kind == sdramPkg::read) && !wrStart;
    assign wrStop  = rdStart || (cmdNow.cmd == sdramPkg::read && cmdOpen) ||
                     cmdNow.cmd == sdramPkg::burstTerm ||
                     (cmdNow.cmd == sdramPkg::precharge &&
                      (cmdNow.addr.colWord.autoPre || cmdNow.bank == actBank));
    assign rdStop  = wrStart || casPipe[0].kind == sdramPkg::burstTerm ||
                     (casPipe[0].kind == sdramPkg::precharge &&
                      (casPipe[0].allBanks || casPipe[0].bank == actBank));

    // Array access, a new burst drives its first column directly
    assign starting = wrStart || rdStart;
    assign selBank  = wrStart ? cmdNow.bank : casPipe[0].bank;
    assign newCol   = wrStart ? cmdCol : pipeCol[0];
    assign arrWrEn  = wrStart || (wrActive && !wrStop);
    assign arrRdEn  = rdStart || (rdActive && !rdStop);
    assign arrBank  = starting ? selBank : actBank;
    assign arrRow   = starting ? openRows[selBank] : actRow;
    assign arrCol   = starting ? newCol : burstCol(startCol, beatCnt, wrapMask, mode.burstType);

    // ******************************************************************
    // CAS latency pipeline
    // ******************************************************************
    always_ff @(posedge Clk) begin
        if (!rstN) begin
            casPipe[0] <= idleEntry;
            casPipe[1] <= idleEntry;
        end else begin
            casPipe[0] <= casPipe[1];
            casPipe[1] <= idleEntry;
            if (pipeIn && mode.casLatency == 3'd3) begin
                casPipe[1] <= '{kind: cmdNow.cmd, bank: cmdNow.bank,
                                allBanks: cmdNow.addr.colWord.autoPre};
            end else if (pipeIn) begin
                casPipe[0] <= '{kind: cmdNow.cmd, bank: cmdNow.bank,
                                allBanks: cmdNow.addr.colWord.autoPre};
            end
        end
    end

    always_ff @(posedge Clk) begin
        pipeCol[0] <= (mode.casLatency == 3'd3) ? pipeCol[1] : cmdCol;
        pipeCol[1] <= cmdCol;
    end

    // ******************************************************************
    // Running burst
    // ******************************************************************
    always_ff @(posedge Clk) begin
        if (!rstN) begin
            rdActive <= 1'b0;
            wrActive <= 1'b0;
            dqOe     <= 1'b0;
        end else begin
            dqOe <= arrRdEn;
            if (starting) begin
                // BL 1 is done with the first beat
                rdActive <= rdStart && (wrapMask != 3'd0);
                wrActive <= wrStart && (wrapMask != 3'd0);
            end else begin
                if (rdStop || lastBeat) begin
                    rdActive <= 1'b0;
                end
                if (wrStop || lastBeat) begin
                    wrActive <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (starting) begin
            actBank  <= selBank;
            actRow   <= openRows[selBank];
            startCol <= newCol;
            beatCnt  <= 3'd1;
        end else begin
            beatCnt <= beatCnt + 3'd1;
        end
    end

    oneArrayPort: assert property (@(posedge Clk) disable iff (!rstN) !(arrWrEn && arrRdEn))
        else $error("array written and read in the same cycle");

endmodule

`default_nettype wire

//--- verilog/sdramArray.sv
// Storage has no reset; depth is 2**(rowBits+colBits) words per bank, keep it small
`default_nettype none

module sdramArray #(
    parameter int rowBits = 6,
    parameter int colBits = 8
) (
    input  logic                          Clk,
    input  logic                          arrWrEn,
    input  logic                          arrRdEn,
    input  logic [sdramPkg::bankBits-1:0] arrBank,
    input  logic [rowBits-1:0]            arrRow,
    input  logic [colBits-1:0]            arrCol,
    input  logic [sdramPkg::dataBits-1:0] dqIn,
    output logic [sdramPkg::dataBits-1:0] dqOut
);

    localparam int memDepth = 2 ** (rowBits + colBits);

    // One word array per bank, indexed by row then column
    logic [sdramPkg::dataBits-1:0] mem [sdramPkg::numBanks][memDepth];

    logic [rowBits+colBits-1:0]    wordAddr;

    assign wordAddr = {arrRow, arrCol};

    // Write on the edge, read registered into the output
    always_ff @(posedge Clk) begin
        if (arrWrEn) begin
            mem[arrBank][wordAddr] <= dqIn;
        end
        if (arrRdEn) begin
            dqOut <= mem[arrBank][wordAddr];
        end
    end

endmodule

`default_nettype wire

//--- verilog/sdramDevice.sv
// Cycle model of a four-bank SDR SDRAM; no timing checks, refresh, DQM or CKE, DQ split in two
`default_nettype none

module sdramDevice #(
    parameter int rowBits = 6,
    parameter int colBits = 8
) (
    input  logic                          Clk,
    input  logic                          rstN,
    input  logic                          csN,
    input  logic                          rasN,
    input  logic                          casN,
    input  logic                          weN,
    input  logic [sdramPkg::bankBits-1:0] ba,
    input  logic [sdramPkg::addrBits-1:0] addr,
    input  logic [sdramPkg::dataBits-1:0] dqIn,
    output logic [sdramPkg::dataBits-1:0] dqOut,
    output logic                          dqOe,
    output logic                          protoErr
);

    sdramPkg::sdramCmdT                         cmdNow;
    sdramPkg::sdramModeT                        mode;
    logic [sdramPkg::numBanks-1:0][rowBits-1:0] openRows;
    logic [sdramPkg::numBanks-1:0]              bankOpen;
    logic                                       arrWrEn;
    logic                                       arrRdEn;
    logic [sdramPkg::bankBits-1:0]              arrBank;
    logic [rowBits-1:0]                         arrRow;
    logic [colBits-1:0]                         arrCol;

    sdramCmdDecode cmdDecode_i (
        .Clk(Clk), .rstN(rstN), .csN(csN), .rasN(rasN), .casN(casN), .weN(weN),
        .ba(ba), .addr(addr), .cmdNow(cmdNow), .mode(mode)
    );

    sdramBankState #(.rowBits(rowBits)) bankState_i (
        .Clk(Clk), .rstN(rstN), .cmdNow(cmdNow),
        .openRows(openRows), .bankOpen(bankOpen), .protoErr(protoErr)
    );

    sdramBurstCtrl #(.rowBits(rowBits), .colBits(colBits)) burstCtrl_i (
        .Clk(Clk), .rstN(rstN), .cmdNow(cmdNow), .mode(mode),
        .openRows(openRows), .bankOpen(bankOpen),
        .arrWrEn(arrWrEn), .arrRdEn(arrRdEn), .arrBank(arrBank),
        .arrRow(arrRow), .arrCol(arrCol), .dqOe(dqOe)
    );

    sdramArray #(.rowBits(rowBits), .colBits(colBits)) array_i (
        .Clk(Clk), .arrWrEn(arrWrEn), .arrRdEn(arrRdEn), .arrBank(arrBank),
        .arrRow(arrRow), .arrCol(arrCol), .dqIn(dqIn), .dqOut(dqOut)
    );

endmodule

`default_nettype wire

//--- test/sdramDevice_tb.sv
// One stimulus line is one bus cycle (NOP lines repeat); rowBits 6 and colBits 8 are assumed
`default_nettype none

module sdramDevice_tb;

    localparam int rowBits  = 6;
    localparam int colBits  = 8;
    localparam int maxSlots = 512;
    localparam int maxTests = 16;

    logic                          Clk;
    logic                          rstN;
    logic                          csN;
    logic                          rasN;
    logic                          casN;
    logic                          weN;
    logic [sdramPkg::bankBits-1:0] ba;
    logic [sdramPkg::addrBits-1:0] addr;
    logic [sdramPkg::dataBits-1:0] dqIn;
    logic [sdramPkg::dataBits-1:0] dqOut;
    logic                          dqOe;
    logic                          protoErr;

    // Reference memory, bank flags and mode
    logic [7:0]         modelMem [4][2**(rowBits+colBits)];
    logic [rowBits-1:0] modelRow [4];
    logic [3:0]         modelOpen;
    int                 modeBl;
    int                 modeCl;
    logic               modeInter;
    int                 wrLeft;
    int                 wrBeat;
    int                 wrBank;
    int                 wrCol;

    // Expected outputs per sampling slot
    logic               expOe [maxSlots];
    logic [7:0]         expData [maxSlots];
    logic               expErr [maxSlots];
    int                 slotTest [maxSlots];
    int                 slot;
    int                 testErrs [maxTests];
    int                 testEnd [maxTests];
    logic               testSeen [maxTests];
    logic               testDone [maxTests];
    int                 curTest;
    logic               draining;
    int                 passCount;
    int                 failCount;
    int                 strayErrs;
    int                 cycleCount;
    int                 cycleLimit;

    sdramDevice #(.rowBits(rowBits), .colBits(colBits)) dut_i (
        .Clk(Clk), .rstN(rstN), .csN(csN), .rasN(rasN), .casN(casN), .weN(weN),
        .ba(ba), .addr(addr), .dqIn(dqIn), .dqOut(dqOut), .dqOe(dqOe), .protoErr(protoErr)
    );

    initial begin
        Clk = 1'b0;
        forever #20 Clk = ~Clk;
    end

    // Column of beat k, wrapped within the burst block
    function automatic int burstColumn(input int start, input int beat, input int bl,
                                       input logic inter);
        int mask;
        int low;
        mask = bl - 1;
        low = inter ? (start ^ beat) : (start + beat);
        return (start & ~mask) | (low & mask);
    endfunction

    function automatic int wordIndex(input int bank, input int col);
        return int'(modelRow[bank]) * (2 ** colBits) + col;
    endfunction

    task automatic noteTest(input int test, input int j);
        slotTest[j] = test;
        testSeen[test] = 1'b1;
        if (j > testEnd[test]) begin
            testEnd[test] = j;
        end
    endtask

    task automatic storeBeat(input int data);
        int col;
        col = burstColumn(wrCol, wrBeat, modeBl, modeInter);
        modelMem[wrBank][wordIndex(wrBank, col)] = data[7:0];
        wrBeat = wrBeat + 1;
        wrLeft = wrLeft - 1;
    endtask

    // ******************************************************************
    // One bus cycle, driven and applied to the reference model
    // ******************************************************************
    task automatic driveCycle(input string name, input int bank, input int a,
                              input int data, input int test);
        logic [2:0] strobes;
        int         k;
        int         j;
        strobes = 3'b111;
        if (test > 0) begin
            curTest = test;
            noteTest(test, slot);
        end
        if (wrLeft > 0 && (name == "DAT" || name == "NOP")) begin
            storeBeat(data);
        end else begin
            wrLeft = 0;
        end
        case (name)
            "MRS": begin
                strobes = 3'b000;
                modeBl = 1 << (a & 7);
                modeInter = a[3];
                modeCl = (a >> 4) & 7;
                expErr[slot+1] = |modelOpen;
            end
            "REF": begin
                strobes = 3'b001;
                expErr[slot+1] = |modelOpen;
            end
            "PRE": begin
                strobes = 3'b010;
                if (a[10]) begin
                    modelOpen = 4'b0000;
                end else begin
                    modelOpen[bank] = 1'b0;
                end
            end
            "ACT": begin
                strobes = 3'b011;
                modelOpen[bank] = 1'b1;
                modelRow[bank] = a[rowBits-1:0];
            end
            "WR": begin
                strobes = 3'b100;
                if (modelOpen[bank]) begin
                    wrBank = bank;
                    wrCol = a & 255;
                    wrBeat = 0;
                    wrLeft = modeBl;
                    storeBeat(data);
                end else begin
                    expErr[slot+1] = 1'b1;
                end
            end
            "RD": begin
                strobes = 3'b101;
                if (modelOpen[bank]) begin
                    // The file gives the beat count after any truncation
                    for (k = 0; k < data; k++) begin
                        j = slot + modeCl + k;
                        expOe[j] = 1'b1;
                        expData[j] = modelMem[bank][wordIndex(bank,
                                     burstColumn(a & 255, k, modeBl, modeInter))];
                        noteTest(test, j);
                    end
                end else begin
                    expErr[slot+1] = 1'b1;
                    noteTest(test, slot + 1);
                end
            end
            "BST": strobes = 3'b110;
            default: strobes = 3'b111;
        endcase
        csN <= 1'b0;
        {rasN, casN, weN} <= strobes;
        ba <= bank[1:0];
        addr <= a[12:0];
        dqIn <= data[7:0];
    endtask

    task automatic checkSlot(input int j);
        int t;
        t = slotTest[j];
        if (dqOe !== expOe[j]) begin
            if (expOe[j]) begin
                $display("time %0t: dqOe stayed low for an expected read beat", $time);
            end else begin
                $display("time %0t: dqOe went high with no read beat due", $time);
            end
            testErrs[t] = testErrs[t] + 1;
        end else if (expOe[j] && dqOut !== expData[j]) begin
            $display("MISMATCH time %0t: dqOut is %h, expected %h", $time, dqOut, expData[j]);
            testErrs[t] = testErrs[t] + 1;
        end
        if (protoErr !== expErr[j]) begin
            if (expErr[j]) begin
                $display("time %0t: protoErr missing after an illegal command", $time);
            end else begin
                $display("time %0t: protoErr raised with no illegal command", $time);
            end
            testErrs[t] = testErrs[t] + 1;
        end
    endtask

    task automatic reportFinished(input int j);
        int t;
        for (t = 1; t < maxTests; t++) begin
            if (testSeen[t] && !testDone[t] && testEnd[t] <= j && (t != curTest || draining)) begin
                testDone[t] = 1'b1;
                if (testErrs[t] == 0) begin
                    passCount = passCount + 1;
                    $display("test %0d finished: ok", t);
                end else begin
                    failCount = failCount + 1;
                    $display("test %0d finished: %0d errors", t, testErrs[t]);
                end
            end
        end
    endtask

    // Outputs are stable at the falling edge
    always @(negedge Clk) begin
        if (slot >= 0) begin
            checkSlot(slot);
            reportFinished(slot);
        end
    end

    always @(posedge Clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit > 0 && cycleCount > cycleLimit) begin
            $display("timeout: the run went past %0d cycles", cycleLimit);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // ******************************************************************
    // Stimulus reader and main sequence
    // ******************************************************************
    initial begin
        int    fd;
        int    n;
        int    i;
        int    r;
        int    b;
        int    w;
        int    reps;
        string text;
        string name;
        int    bank;
        int    a;
        int    data;
        int    test;
        string cmdQ [$];
        int    bankQ [$];
        int    addrQ [$];
        int    dataQ [$];
        int    testQ [$];
        csN = 1'b1;
        rasN = 1'b1;
        casN = 1'b1;
        weN = 1'b1;
        ba = '0;
        addr = '0;
        dqIn = '0;
        rstN = 1'b0;
        slot = -1;
        cycleCount = 0;
        cycleLimit = 0;
        draining = 1'b0;
        curTest = 0;
        passCount = 0;
        failCount = 0;
        strayErrs = 0;
        modelOpen = 4'b0000;
        modeBl = 1;
        modeCl = 2;
        modeInter = 1'b0;
        wrLeft = 0;
        wrBeat = 0;
        wrBank = 0;
        wrCol = 0;
        for (b = 0; b < 4; b++) begin
            modelRow[b] = '0;
            for (w = 0; w < 2 ** (rowBits + colBits); w++) begin
                modelMem[b][w] = 8'h00;
            end
        end
        for (i = 0; i < maxSlots; i++) begin
            expOe[i] = 1'b0;
            expData[i] = 8'h00;
            expErr[i] = 1'b0;
            slotTest[i] = 0;
        end
        for (i = 0; i < maxTests; i++) begin
            testErrs[i] = 0;
            testEnd[i] = 0;
            testSeen[i] = 1'b0;
            testDone[i] = 1'b0;
        end

        fd = $fopen("test/sdramStimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open test/sdramStimulus.txt");
            failCount = failCount + 1;
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(text, fd);
                if (n > 0 && text.substr(0, 0) != "#") begin
                    n = $sscanf(text, "%s %h %h %h %d", name, bank, a, data, test);
                    if (n == 5) begin
                        cmdQ.push_back(name);
                        bankQ.push_back(bank);
                        addrQ.push_back(a);
                        dataQ.push_back(data);
                        testQ.push_back(test);
                    end
                end
            end
            $fclose(fd);
        end
        cycleLimit = 40 * cmdQ.size() + 100;

        repeat (5) @(posedge Clk);
        rstN <= 1'b1;
        @(posedge Clk);
        for (i = 0; i < cmdQ.size(); i++) begin
            reps = (cmdQ[i] == "NOP") ? dataQ[i] : 1;
            for (r = 0; r < reps; r++) begin
                @(posedge Clk);
                slot = slot + 1;
                driveCycle(cmdQ[i], bankQ[i], addrQ[i], dataQ[i], testQ[i]);
            end
        end
        draining = 1'b1;
        repeat (12) begin
            @(posedge Clk);
            slot = slot + 1;
            driveCycle("NOP", 0, 0, 0, 0);
        end
        @(posedge Clk);

        for (i = 1; i < maxTests; i++) begin
            if (testSeen[i] && !testDone[i]) begin
                $display("test %0d never reached its end", i);
                failCount = failCount + 1;
            end
        end
        strayErrs = testErrs[0];
        $display("tests passed %0d, failed %0d, errors outside tests %0d",
                 passCount, failCount, strayErrs);
        if (failCount == 0 && strayErrs == 0 && passCount > 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sdramDevice.f
verilog/sdramPkg.sv
verilog/sdramCmdDecode.sv
verilog/sdramBankState.sv
verilog/sdramBurstCtrl.sv
verilog/sdramArray.sv
verilog/sdramDevice.sv
test/sdramDevice_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the SDRAM model testbench with Verilator, runs it and checks the log.
set -u
cd "$(dirname "$0")"

if ! verilator --binary --timing -f sdramDevice.f --top-module sdramDevice_tb -o simv; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simv > sim.log 2>&1
simStatus=$?
cat sim.log
if [ "$simStatus" -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -qF '*** FAILED ***' sim.log; then
    exit 1
fi
exit 0

//--- test/sdramStimulus.txt
# cmd bank addr data test: hex fields; data is write data, beat count on RD, cycle count on NOP
# PRE with addr 400 closes all banks; MRS addr gives BL code 2:0, interleave bit 3, CL bits 6:4
MRS 0 032 00 1
ACT 1 005 00 1
WR  1 010 11 1
DAT 0 000 22 1
DAT 0 000 33 1
DAT 0 000 44 1
RD  1 010 04 1
NOP 0 000 04 1
PRE 0 400 00 2
MRS 0 03b 00 2
ACT 1 005 00 2
RD  1 013 08 2
NOP 0 000 08 2
PRE 0 400 00 3
MRS 0 021 00 3
ACT 0 009 00 3
ACT 2 009 00 3
WR  0 020 a1 3
DAT 0 000 a2 3
WR  2 020 c1 3
DAT 0 000 c2 3
RD  0 020 02 3
NOP 0 000 01 3
RD  2 020 02 3
NOP 0 000 02 3
PRE 0 400 00 4
MRS 0 023 00 4
ACT 1 005 00 4
RD  1 010 03 4
NOP 0 000 02 4
BST 0 000 00 4
RD  1 010 05 4
NOP 0 000 04 4
PRE 0 400 00 4
ACT 1 005 00 5
WR  1 010 55 5
DAT 0 000 66 5
BST 0 000 77 5
RD  1 010 08 5
NOP 0 000 08 5
PRE 1 000 00 6
RD  1 010 00 6
NOP 0 000 03 6
